// ==== verilog/rv32i_pkg.sv ====
package rv32i_pkg;

    localparam int unsigned XLEN      = 32;
    localparam int unsigned REG_IDX_W = 5;
    localparam int unsigned SHAMT_W   = 5;

    typedef logic [XLEN-1:0]      rv32i_word;
    typedef logic [REG_IDX_W-1:0] rv32i_reg;

    // sequential instruction step
    localparam rv32i_word PC_STEP = 32'd4;

    // funct3 order, sub and sra take the spare codes
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    // branch funct3 encoding
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic {
        alumux1_rs1_out = 1'b0,
        alumux1_pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm   = 3'd0,
        alumux2_u_imm   = 3'd1,
        alumux2_b_imm   = 3'd2,
        alumux2_s_imm   = 3'd3,
        alumux2_j_imm   = 3'd4,
        alumux2_rs2_out = 3'd5
    } alumux2_sel_t;

    typedef enum logic {
        cmpmux_rs2_out = 1'b0,
        cmpmux_i_imm   = 1'b1
    } cmpmux_sel_t;

    // no loads here, so four sources are enough
    typedef enum logic [1:0] {
        regfilemux_alu_out  = 2'd0,
        regfilemux_br_en    = 2'd1,
        regfilemux_u_imm    = 2'd2,
        regfilemux_pc_plus4 = 2'd3
    } regfilemux_sel_t;

    typedef enum logic [2:0] {
        fwd_id_ex        = 3'd0,
        fwd_ex_mem       = 3'd1,
        fwd_u_imm_ex_mem = 3'd2,
        fwd_br_en_ex_mem = 3'd3,
        fwd_pc4_ex_mem   = 3'd4,
        fwd_mem_wb       = 3'd5
    } fwd_sel_t;

    typedef struct packed {
        logic            load_regfile;
        alu_ops          aluop;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        branch_funct3_t  cmpop;
        cmpmux_sel_t     cmpmux_sel;
        regfilemux_sel_t regfilemux_sel;
    } rv32i_control_word;

    typedef struct packed {
        logic              valid;
        rv32i_reg          rs1;
        rv32i_reg          rs2;
        rv32i_reg          rd;
        rv32i_word         pc;
        rv32i_word         rs1_out;
        rv32i_word         rs2_out;
        rv32i_word         i_imm;
        rv32i_word         s_imm;
        rv32i_word         b_imm;
        rv32i_word         u_imm;
        rv32i_word         j_imm;
        rv32i_control_word ctrl;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        rv32i_reg          rd;
        rv32i_control_word ctrl;
        rv32i_word         alu_out;
        logic              br_en;
        rv32i_word         u_imm;
        rv32i_word         pc_plus4;
    } ex_mem_t;

    // same layout as ex_mem_t for now
    typedef struct packed {
        logic              valid;
        rv32i_reg          rd;
        rv32i_control_word ctrl;
        rv32i_word         alu_out;
        logic              br_en;
        rv32i_word         u_imm;
        rv32i_word         pc_plus4;
    } mem_wb_t;

    typedef struct packed {
        logic      we;
        rv32i_reg  rd;
        rv32i_word data;
    } wb_port_t;

endpackage : rv32i_pkg

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu
    import rv32i_pkg::*;
(
    input  alu_ops    aluop_i,
    input  rv32i_word a_i,
    input  rv32i_word b_i,
    output rv32i_word f_o
);

    logic [SHAMT_W-1:0] shamt;

    // only the low bits of b count for shifts
    assign shamt = b_i[SHAMT_W-1:0];

    always_comb begin
        unique case (aluop_i)
            alu_add: f_o = a_i + b_i;
            alu_sll: f_o = a_i << shamt;
            alu_sra: f_o = rv32i_word'($signed(a_i) >>> shamt);
            alu_sub: f_o = a_i - b_i;
            alu_xor: f_o = a_i ^ b_i;
            alu_srl: f_o = a_i >> shamt;
            alu_or:  f_o = a_i | b_i;
            alu_and: f_o = a_i & b_i;
            default: f_o = a_i + b_i;
        endcase
    end

endmodule : alu

// ==== verilog/branch_cmp.sv ====
`timescale 1ns/1ps

module branch_cmp
    import rv32i_pkg::*;
(
    input  branch_funct3_t cmpop_i,
    input  rv32i_word      a_i,
    input  rv32i_word      b_i,
    output logic           br_en_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    // slt/sltu reuse blt/bltu
    always_comb begin
        unique case (cmpop_i)
            beq:     br_en_o = eq;
            bne:     br_en_o = ~eq;
            blt:     br_en_o = lt_s;
            bge:     br_en_o = ~lt_s;
            bltu:    br_en_o = lt_u;
            bgeu:    br_en_o = ~lt_u;
            default: br_en_o = 1'b0;
        endcase
    end

endmodule : branch_cmp

// ==== verilog/forwarding_unit.sv ====
`timescale 1ns/1ps

module forwarding_unit
    import rv32i_pkg::*;
(
    input  rv32i_reg rs1_i,
    input  rv32i_reg rs2_i,
    input  ex_mem_t  ex_mem_i,
    input  mem_wb_t  mem_wb_i,
    output fwd_sel_t fwd_a_o,
    output fwd_sel_t fwd_b_o
);

    // picks the source for one operand, newest stage first
    function automatic fwd_sel_t pick_src(
        input rv32i_reg rs,
        input ex_mem_t  ex_mem,
        input mem_wb_t  mem_wb
    );
        logic     hit_ex_mem;
        logic     hit_mem_wb;
        fwd_sel_t sel;

        hit_ex_mem = ex_mem.valid && ex_mem.ctrl.load_regfile
                     && (ex_mem.rd != '0) && (ex_mem.rd == rs);
        hit_mem_wb = mem_wb.valid && mem_wb.ctrl.load_regfile
                     && (mem_wb.rd != '0) && (mem_wb.rd == rs);
        sel = fwd_id_ex;
        if (hit_ex_mem) begin
            // value not selected yet in ex/mem, take the matching field
            unique case (ex_mem.ctrl.regfilemux_sel)
                regfilemux_alu_out:  sel = fwd_ex_mem;
                regfilemux_br_en:    sel = fwd_br_en_ex_mem;
                regfilemux_u_imm:    sel = fwd_u_imm_ex_mem;
                regfilemux_pc_plus4: sel = fwd_pc4_ex_mem;
                default:             sel = fwd_ex_mem;
            endcase
        end else if (hit_mem_wb) begin
            sel = fwd_mem_wb;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a_o = pick_src(rs1_i, ex_mem_i, mem_wb_i);
        fwd_b_o = pick_src(rs2_i, ex_mem_i, mem_wb_i);
    end

endmodule : forwarding_unit

// ==== verilog/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage
    import rv32i_pkg::*;
(
    input  id_ex_t    id_ex_i,
    input  fwd_sel_t  fwd_a_i,
    input  fwd_sel_t  fwd_b_i,
    input  ex_mem_t   ex_mem_fwd_i,
    input  rv32i_word mem_wb_data_i,
    output ex_mem_t   ex_mem_o
);

    rv32i_word fwd_a_val;
    rv32i_word fwd_b_val;
    rv32i_word alumux1_out;
    rv32i_word alumux2_out;
    rv32i_word cmpmux_out;
    rv32i_word alu_out;
    logic      br_en;

    // one forwarding mux, used for both operands
    function automatic rv32i_word fwd_mux(
        input fwd_sel_t  sel,
        input rv32i_word rf_val,
        input ex_mem_t   ex_mem,
        input rv32i_word wb_val
    );
        rv32i_word val;

        unique case (sel)
            fwd_id_ex:        val = rf_val;
            fwd_ex_mem:       val = ex_mem.alu_out;
            fwd_u_imm_ex_mem: val = ex_mem.u_imm;
            fwd_br_en_ex_mem: val = {{(XLEN-1){1'b0}}, ex_mem.br_en};
            fwd_pc4_ex_mem:   val = ex_mem.pc_plus4;
            fwd_mem_wb:       val = wb_val;
            default:          val = rf_val;
        endcase
        return val;
    endfunction

    always_comb begin
        fwd_a_val = fwd_mux(fwd_a_i, id_ex_i.rs1_out, ex_mem_fwd_i, mem_wb_data_i);
        fwd_b_val = fwd_mux(fwd_b_i, id_ex_i.rs2_out, ex_mem_fwd_i, mem_wb_data_i);
    end

    // alu operand selection
    always_comb begin
        unique case (id_ex_i.ctrl.alumux1_sel)
            alumux1_rs1_out: alumux1_out = fwd_a_val;
            alumux1_pc_out:  alumux1_out = id_ex_i.pc;
            default:         alumux1_out = fwd_a_val;
        endcase

        unique case (id_ex_i.ctrl.alumux2_sel)
            alumux2_i_imm:   alumux2_out = id_ex_i.i_imm;
            alumux2_u_imm:   alumux2_out = id_ex_i.u_imm;
            alumux2_b_imm:   alumux2_out = id_ex_i.b_imm;
            alumux2_s_imm:   alumux2_out = id_ex_i.s_imm;
            alumux2_j_imm:   alumux2_out = id_ex_i.j_imm;
            alumux2_rs2_out: alumux2_out = fwd_b_val;
            default:         alumux2_out = fwd_b_val;
        endcase
    end

    // compare against rs2 for branches/slt, i_imm for slti/sltiu
    always_comb begin
        unique case (id_ex_i.ctrl.cmpmux_sel)
            cmpmux_rs2_out: cmpmux_out = fwd_b_val;
            cmpmux_i_imm:   cmpmux_out = id_ex_i.i_imm;
            default:        cmpmux_out = fwd_b_val;
        endcase
    end

    alu i_alu (
        .aluop_i (id_ex_i.ctrl.aluop),
        .a_i     (alumux1_out),
        .b_i     (alumux2_out),
        .f_o     (alu_out)
    );

    branch_cmp i_branch_cmp (
        .cmpop_i (id_ex_i.ctrl.cmpop),
        .a_i     (fwd_a_val),
        .b_i     (cmpmux_out),
        .br_en_o (br_en)
    );

    always_comb begin
        ex_mem_o.valid    = id_ex_i.valid;
        ex_mem_o.rd       = id_ex_i.rd;
        ex_mem_o.ctrl     = id_ex_i.ctrl;
        ex_mem_o.alu_out  = alu_out;
        ex_mem_o.br_en    = br_en;
        ex_mem_o.u_imm    = id_ex_i.u_imm;
        ex_mem_o.pc_plus4 = id_ex_i.pc + PC_STEP;
    end

endmodule : ex_stage

// ==== verilog/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // no stall, so the stage loads every cycle
    // reset zeroes the whole payload, valid included
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule : stage_reg

// ==== verilog/wb_select.sv ====
`timescale 1ns/1ps

module wb_select
    import rv32i_pkg::*;
(
    input  mem_wb_t  mem_wb_i,
    output wb_port_t wb_o
);

    rv32i_word wb_data;

    always_comb begin
        unique case (mem_wb_i.ctrl.regfilemux_sel)
            regfilemux_alu_out:  wb_data = mem_wb_i.alu_out;
            regfilemux_br_en:    wb_data = {{(XLEN-1){1'b0}}, mem_wb_i.br_en};
            regfilemux_u_imm:    wb_data = mem_wb_i.u_imm;
            regfilemux_pc_plus4: wb_data = mem_wb_i.pc_plus4;
            default:             wb_data = mem_wb_i.alu_out;
        endcase
    end

    // writes to x0 are dropped here
    always_comb begin
        wb_o.we   = mem_wb_i.valid && mem_wb_i.ctrl.load_regfile
                    && (mem_wb_i.rd != '0);
        wb_o.rd   = mem_wb_i.rd;
        wb_o.data = wb_data;
    end

endmodule : wb_select

// ==== verilog/ex_subsystem.sv ====
`timescale 1ns/1ps

module ex_subsystem
    import rv32i_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  id_ex_t   id_ex_i,
    output wb_port_t wb_o
);

    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_q;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    forwarding_unit i_forwarding_unit (
        .rs1_i    (id_ex_i.rs1),
        .rs2_i    (id_ex_i.rs2),
        .ex_mem_i (ex_mem_q),
        .mem_wb_i (mem_wb_q),
        .fwd_a_o  (fwd_a),
        .fwd_b_o  (fwd_b)
    );

    // writeback data doubles as the mem/wb forward
    ex_stage i_ex_stage (
        .id_ex_i       (id_ex_i),
        .fwd_a_i       (fwd_a),
        .fwd_b_i       (fwd_b),
        .ex_mem_fwd_i  (ex_mem_q),
        .mem_wb_data_i (wb_o.data),
        .ex_mem_o      (ex_mem_d)
    );

    stage_reg #(
        .payload_t (ex_mem_t)
    ) i_ex_mem_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .d_i     (ex_mem_d),
        .q_o     (ex_mem_q)
    );

    // mem stage is empty, payload moves straight on
    stage_reg #(
        .payload_t (mem_wb_t)
    ) i_mem_wb_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .d_i     (mem_wb_t'(ex_mem_q)),
        .q_o     (mem_wb_q)
    );

    wb_select i_wb_select (
        .mem_wb_i (mem_wb_q),
        .wb_o     (wb_o)
    );

endmodule : ex_subsystem

// ==== tb/ex_subsystem_properties.sv ====
`timescale 1ns/1ps

module ex_subsystem_properties
    import rv32i_pkg::*;
(
    input logic     clk_i,
    input logic     rst_n_i,
    input id_ex_t   id_ex_i,
    input wb_port_t wb_i
);

    int unsigned fail_cnt = 0;
    logic        issue_write;

    // bundle that has to reach the register file
    assign issue_write = id_ex_i.valid && id_ex_i.ctrl.load_regfile && (id_ex_i.rd != '0);

    x0_never_written: assert property (@(posedge clk_i) wb_i.we |-> (wb_i.rd != '0))
        else begin
            $error("write enable raised for x0");
            fail_cnt++;
        end

    quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !wb_i.we)
        else begin
            $error("write enable raised during reset");
            fail_cnt++;
        end

    // two rising edges from id_ex to the write port
    write_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(issue_write, 2) |-> wb_i.we)
        else begin
            $error("no write two edges after a loading bundle");
            fail_cnt++;
        end

    invalid_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$past(id_ex_i.valid, 2) |-> !wb_i.we)
        else begin
            $error("write caused by an invalid bundle");
            fail_cnt++;
        end

endmodule : ex_subsystem_properties

bind ex_subsystem ex_subsystem_properties i_properties (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .id_ex_i (id_ex_i),
    .wb_i    (wb_o)
);

// ==== tb/tb_ex_subsystem.sv ====
`timescale 1ns/1ps

module tb_ex_subsystem
    import rv32i_pkg::*;
();

    localparam int unsigned N_INSTR       = 400;
    localparam int unsigned RST_CYCLES    = 16;
    localparam int unsigned CLK_PERIOD_NS = 100;
    localparam int unsigned LIMIT_CYCLES  = RST_CYCLES + N_INSTR + 20;

    logic        clk_i     = 1'b0;
    logic        rst_n_i   = 1'b0;
    id_ex_t      id_ex_i   = '0;
    wb_port_t    wb_o;
    rv32i_word   rf [8];
    rv32i_word   true_rf [8];
    wb_port_t    exp_q [$];
    logic [31:0] lcg_state = 32'hdc7d838f;
    int unsigned err_cnt   = 0;
    int unsigned prop_errs;

    ex_subsystem i_ex_subsystem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .id_ex_i (id_ex_i),
        .wb_o    (wb_o)
    );

    always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

    // external register file that lags program order by the pipeline depth
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 8; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_o.we && (wb_o.rd[2:0] != 3'd0)) begin
            rf[wb_o.rd[2:0]] <= wb_o.data;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits only since the low LCG bits repeat quickly
    function automatic logic [2:0] pick3();
        logic [31:0] r;
        r = next_rand();
        return r[31:29];
    endfunction

    function automatic rv32i_word alu_ref(
        input alu_ops    op,
        input rv32i_word a,
        input rv32i_word b
    );
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_sll: return a << b[4:0];
            alu_srl: return a >> b[4:0];
            alu_sra: return rv32i_word'($signed(a) >>> b[4:0]);
            alu_xor: return a ^ b;
            alu_or:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // builds one bundle and the writeback it must cause two edges later
    task automatic issue(input logic valid);
        id_ex_t      ins;
        wb_port_t    want;
        rv32i_word   a;
        rv32i_word   b;
        logic [31:0] r;
        logic [2:0]  sub;

        ins         = '0;
        want        = '0;
        ins.valid   = valid;
        ins.rs1     = {2'b00, pick3()};
        ins.rs2     = {2'b00, pick3()};
        ins.rd      = {2'b00, pick3()};
        ins.pc      = next_rand() & 32'hffff_fffc;
        ins.rs1_out = rf[ins.rs1[2:0]];
        ins.rs2_out = rf[ins.rs2[2:0]];
        r           = next_rand();
        ins.i_imm   = {{20{r[31]}}, r[31:20]};
        ins.s_imm   = {{20{r[11]}}, r[11:0]};
        r           = next_rand();
        ins.u_imm   = {r[31:12], 12'h000};
        ins.j_imm   = {{11{r[20]}}, r[20:1], 1'b0};
        ins.b_imm   = {{19{r[12]}}, r[12:1], 1'b0};
        a           = true_rf[ins.rs1[2:0]];
        b           = true_rf[ins.rs2[2:0]];
        sub         = pick3();
        ins.ctrl.load_regfile = 1'b1;
        case (pick3())
            3'd0: begin
                ins.ctrl.aluop       = alu_ops'(sub);
                ins.ctrl.alumux2_sel = alumux2_rs2_out;
                want.data            = alu_ref(ins.ctrl.aluop, a, b);
            end
            3'd1: begin
                // RV32I has no subi
                ins.ctrl.aluop = (alu_ops'(sub) == alu_sub) ? alu_add : alu_ops'(sub);
                want.data      = alu_ref(ins.ctrl.aluop, a, ins.i_imm);
            end
            3'd2, 3'd3: begin
                // slt, sltu, slti, sltiu
                ins.ctrl.cmpop          = sub[0] ? blt : bltu;
                ins.ctrl.cmpmux_sel     = sub[1] ? cmpmux_i_imm : cmpmux_rs2_out;
                ins.ctrl.regfilemux_sel = regfilemux_br_en;
                if (sub[1]) begin
                    b = ins.i_imm;
                end
                want.data = sub[0] ? rv32i_word'($signed(a) < $signed(b)) : rv32i_word'(a < b);
            end
            3'd4: begin
                ins.ctrl.regfilemux_sel = regfilemux_u_imm;
                want.data               = ins.u_imm;
            end
            3'd5: begin
                // auipc
                ins.ctrl.alumux1_sel = alumux1_pc_out;
                ins.ctrl.alumux2_sel = alumux2_u_imm;
                want.data            = ins.pc + ins.u_imm;
            end
            3'd6: begin
                // jal when sub[0] is set and jalr when it is clear
                ins.ctrl.regfilemux_sel = regfilemux_pc_plus4;
                if (sub[0]) begin
                    ins.ctrl.alumux1_sel = alumux1_pc_out;
                    ins.ctrl.alumux2_sel = alumux2_j_imm;
                end
                want.data = ins.pc + 32'd4;
            end
            default: begin
                // branch that writes nothing
                ins.ctrl.load_regfile = 1'b0;
                ins.ctrl.cmpop        = sub[0] ? bne : bge;
                ins.ctrl.alumux1_sel  = alumux1_pc_out;
                ins.ctrl.alumux2_sel  = alumux2_b_imm;
            end
        endcase
        want.we = valid && ins.ctrl.load_regfile && (ins.rd != '0);
        want.rd = ins.rd;
        if (want.we) begin
            true_rf[ins.rd[2:0]] = want.data;
        end
        id_ex_i = ins;
        exp_q.push_back(want);
    endtask

    task automatic check_wb();
        wb_port_t want;

        want = exp_q.pop_front();
        we_ok: assert (wb_o.we == want.we) else begin
            $display("ERR %0t wb_o.we %0b expected %0b", $time, wb_o.we, want.we);
            err_cnt++;
        end
        if (want.we) begin
            rd_ok: assert (wb_o.rd == want.rd) else begin
                $display("ERR %0t wb_o.rd %0d expected %0d", $time, wb_o.rd, want.rd);
                err_cnt++;
            end
            data_ok: assert (wb_o.data == want.data) else begin
                $display("ERR %0t wb_o.data %h expected %h", $time, wb_o.data, want.data);
                err_cnt++;
            end
        end
    endtask

    initial begin
        for (int i = 0; i < 8; i++) begin
            true_rf[i] = '0;
        end
        // a loading bundle during reset must never reach the write port
        id_ex_i.valid             = 1'b1;
        id_ex_i.ctrl.load_regfile = 1'b1;
        id_ex_i.rd                = 5'd1;
        repeat (RST_CYCLES - 2) @(negedge clk_i);
        // idle for the last two reset edges so nothing is in flight at release
        id_ex_i = '0;
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        repeat (N_INSTR) begin
            @(negedge clk_i);
            if (exp_q.size() == 2) begin
                check_wb();
            end
            issue(pick3() != 3'd0);
        end
        // drain the two bundles still in flight
        repeat (2) begin
            @(negedge clk_i);
            check_wb();
            id_ex_i.valid = 1'b0;
        end
        prop_errs = i_ex_subsystem.i_properties.fail_cnt;
        $display("errors: %0d writeback checks, %0d properties", err_cnt, prop_errs);
        if (err_cnt == 0 && prop_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD_NS);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule : tb_ex_subsystem

// ==== build.f ====
verilog/rv32i_pkg.sv
verilog/alu.sv
verilog/branch_cmp.sv
verilog/forwarding_unit.sv
verilog/ex_stage.sv
verilog/stage_reg.sv
verilog/wb_select.sv
verilog/ex_subsystem.sv
tb/ex_subsystem_properties.sv
tb/tb_ex_subsystem.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

obj_dir/Vtb_ex_subsystem: build.f $(wildcard verilog/*.sv tb/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_ex_subsystem -f build.f

test: obj_dir/Vtb_ex_subsystem
	./obj_dir/Vtb_ex_subsystem +verilator+error+limit+1000 > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
